/* compile.f */
+incdir+rtl
rtl/zbus_pkg.sv
rtl/video_pkg.sv
rtl/zbus_sync.sv
rtl/port_decoder.sv
rtl/video_raster.sv
rtl/video_mixer.sv
rtl/zx_video_top.sv
verification/zx_video_assertions.sv
verification/tb_zx_video.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the zx video testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_zx_video --Mdir obj_dir -f compile.f
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "verilator build returned status $build_status"
	exit $build_status
fi

./obj_dir/Vtb_zx_video
run_status=$?
if [ $run_status -ne 0 ]; then
	echo "simulation returned status $run_status"
	exit $run_status
fi

exit 0

/* verification/tb_zx_video.sv */
`include "video_macros.svh"

`default_nettype none

module tb_zx_video;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;

	logic        fclk;
	logic        rst;
	logic        iorq_n;
	logic        wr_n;
	logic        m1_n;
	logic [15:0] a;
	logic [7:0]  d;
	logic [1:0]  vred;
	logic [1:0]  vgrn;
	logic [1:0]  vblu;
	logic        vhsync;
	logic        vvsync;
	logic        vcsync;
	logic        beep;

	// model of the latched ULA state
	logic [2:0]  border_model;
	logic        beep_model;
	logic        color_hold;
	logic        run;
	logic [31:0] rnd;
	logic [8:0]  exp_pins;
	int          h = 0;
	int          v = 0;
	int          cycles = 0;

	zx_video_top DUT (.*);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// packed as red, green, blue, hsync, vsync, csync
	function automatic logic [8:0] expected_pins(input int hpos, input int vpos,
			input logic [2:0] color);
		logic vis;
		logic hs;
		logic vs;
		vis = (hpos < `H_VISIBLE) && (vpos < `V_VISIBLE);
		hs  = (hpos >= `HSYNC_START) && (hpos < `HSYNC_END);
		vs  = (vpos >= `VSYNC_START) && (vpos < `VSYNC_END);
		if (!vis) begin
			color = 3'b000;
		end
		return {{2{color[1]}}, {2{color[2]}}, {2{color[0]}}, hs, vs, hs | vs};
	endfunction

	task automatic check_pin(input string name, input logic [1:0] expected,
			input logic [1:0] actual);
		assert (actual === expected) else begin
			$display("MISMATCH at %0t ns: %s expected %0d got %0d",
				$time, name, expected, actual);
			$display("sim failed");
			$fatal(1, "output check failed");
		end
	endtask

	// strobes low for 4 cycles, then 12 idle cycles
	task automatic bus_write(input logic [15:0] port, input logic [7:0] data);
		@(negedge fclk);
		color_hold = 1'b1;
		a = port;
		d = data;
		iorq_n = 1'b0;
		wr_n = 1'b0;
		repeat (4) @(negedge fclk);
		iorq_n = 1'b1;
		wr_n = 1'b1;
		if (!port[0]) begin
			border_model = data[2:0];
			beep_model = data[4];
		end
		repeat (8) @(negedge fclk);
		color_hold = 1'b0;
		repeat (4) @(negedge fclk);
	endtask

	initial begin
		fclk = 1'b0;
		forever #4 fclk = ~fclk;
	end

	initial begin
		#(FRAME_CYCLES * 8 * 2.5);
		$display("sim failed");
		$fatal(1, "timeout, the run did not reach two full frames in time");
	end

	always @(posedge fclk) begin
		run <= ~rst;
	end

	// pins at this negedge show the previous cycle's position
	always @(negedge fclk) begin
		if (run) begin
			exp_pins = expected_pins(h, v, border_model);
			check_pin("vhsync", {1'b0, exp_pins[2]}, {1'b0, vhsync});
			check_pin("vvsync", {1'b0, exp_pins[1]}, {1'b0, vvsync});
			check_pin("vcsync", {1'b0, exp_pins[0]}, {1'b0, vcsync});
			if (!color_hold) begin
				check_pin("vred", exp_pins[8:7], vred);
				check_pin("vgrn", exp_pins[6:5], vgrn);
				check_pin("vblu", exp_pins[4:3], vblu);
				check_pin("beep", {1'b0, beep_model}, {1'b0, beep});
			end
			h = h + 1;
			if (h == `H_TOTAL) begin
				h = 0;
				v = (v == `V_TOTAL - 1) ? 0 : v + 1;
			end
			cycles = cycles + 1;
		end
	end

	initial begin
		rst = 1'b1;
		iorq_n = 1'b1;
		wr_n = 1'b1;
		m1_n = 1'b1;
		a = 16'h0000;
		d = 8'h00;
		border_model = 3'b000;
		beep_model = 1'b0;
		color_hold = 1'b0;
		rnd = 32'h6089b23b;
		repeat (5) @(negedge fclk);
		rst = 1'b0;
		// black border right after reset
		repeat (16) @(negedge fclk);
		rnd = xorshift32(rnd);
		bus_write({rnd[15:1], 1'b0}, rnd[23:16]);
		// odd port with inverted data must leave border and beep alone
		bus_write({rnd[15:1], 1'b1}, ~rnd[23:16]);
		for (int i = 0; i < 48; i++) begin
			rnd = xorshift32(rnd);
			repeat (rnd[11:0]) @(negedge fclk);
			rnd = xorshift32(rnd);
			bus_write(rnd[15:0], rnd[31:24]);
		end
		while (cycles < 2 * FRAME_CYCLES) begin
			@(posedge fclk);
		end
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

/* verification/zx_video_assertions.sv */
`include "video_macros.svh"

`default_nettype none

module zx_video_assertions import zbus_pkg::*, video_pkg::*; (
	input wire            fclk,
	input wire            rst,
	input wire            iowr_s,
	input wire hcount_t   hcount,
	input wire vcount_t   vcount,
	input wire zx_color_t border,
	input wire [1:0]      vred,
	input wire [1:0]      vgrn,
	input wire [1:0]      vblu,
	input wire            vhsync,
	input wire            vvsync,
	input wire            vcsync
);
	timeunit 1ns;
	timeprecision 100ps;

	csync_is_or: assert property (@(posedge fclk) disable iff (rst)
		vcsync == (vhsync | vvsync))
		else $error("composite sync differs from hsync OR vsync");

	// blanking follows the raster one cycle late
	blank_outside_visible: assert property (@(posedge fclk) disable iff (rst)
		($past(hcount) >= hcount_t'(`H_VISIBLE) || $past(vcount) >= vcount_t'(`V_VISIBLE))
		|-> (vred == 2'b00 && vgrn == 2'b00 && vblu == 2'b00))
		else $error("colour output not black outside the visible area");

	border_after_write: assert property (@(posedge fclk) disable iff (rst)
		!$stable(border) |-> $past(iowr_s))
		else $error("border changed without a preceding write pulse");

	single_cycle_pulse: assert property (@(posedge fclk) disable iff (rst)
		iowr_s |=> !iowr_s)
		else $error("write pulse lasted more than one cycle");

endmodule

bind zx_video_top zx_video_assertions zx_video_checks (
	.fclk    (fclk),
	.rst     (rst),
	.iowr_s  (iowr_s),
	.hcount  (hcount),
	.vcount  (vcount),
	.border  (border),
	.vred    (vred),
	.vgrn    (vgrn),
	.vblu    (vblu),
	.vhsync  (vhsync),
	.vvsync  (vvsync),
	.vcsync  (vcsync)
);

`default_nettype wire

/* rtl/zx_video_top.sv */
`default_nettype none

module zx_video_top import zbus_pkg::*, video_pkg::*; (
	input  wire        fclk,
	input  wire        rst,

	// z80
	input  wire        iorq_n,
	input  wire        wr_n,
	input  wire        m1_n,
	input  wire [15:0] a,
	input  wire [7:0]  d,

	// video
	output wire rgb2_t vred,
	output wire rgb2_t vgrn,
	output wire rgb2_t vblu,
	output wire        vhsync,
	output wire        vvsync,
	output wire        vcsync,

	output wire        beep
);

	wire         iowr_s;
	wire         port_lsb;
	wire zdata_t wr_data;

	wire zx_color_t border;

	wire hcount_t hcount;
	wire vcount_t vcount;
	wire          hsync;
	wire          vsync;
	wire          visible;

	// only the ULA decode bit of the address matters here
	zbus_sync zbus_sync (
		.fclk     (fclk),
		.rst      (rst),
		.iorq_n   (iorq_n),
		.wr_n     (wr_n),
		.m1_n     (m1_n),
		.a0       (a[ULA_DECODE_BIT]),
		.d        (d),
		.iowr_s   (iowr_s),
		.port_lsb (port_lsb),
		.wr_data  (wr_data)
	);

	port_decoder port_decoder (
		.fclk     (fclk),
		.rst      (rst),
		.iowr_s   (iowr_s),
		.port_lsb (port_lsb),
		.wr_data  (wr_data),
		.border   (border),
		.beep     (beep)
	);

	video_raster video_raster (
		.fclk     (fclk),
		.rst      (rst),
		.hcount   (hcount),
		.vcount   (vcount),
		.hsync    (hsync),
		.vsync    (vsync),
		.visible  (visible)
	);

	video_mixer video_mixer (
		.fclk     (fclk),
		.rst      (rst),
		.hsync    (hsync),
		.vsync    (vsync),
		.visible  (visible),
		.border   (border),
		.vred     (vred),
		.vgrn     (vgrn),
		.vblu     (vblu),
		.vhsync   (vhsync),
		.vvsync   (vvsync),
		.vcsync   (vcsync)
	);

endmodule

`default_nettype wire

/* rtl/video_mixer.sv */
`default_nettype none

module video_mixer import zbus_pkg::*, video_pkg::*; (
	input  wire            fclk,
	input  wire            rst,
	input  wire            hsync,
	input  wire            vsync,
	input  wire            visible,
	input  wire zx_color_t border,
	output rgb2_t          vred,
	output rgb2_t          vgrn,
	output rgb2_t          vblu,
	output logic           vhsync,
	output logic           vvsync,
	output logic           vcsync
);

	rgb2_t red_next;
	rgb2_t grn_next;
	rgb2_t blu_next;
	logic  csync_next;

	// blank outside the visible area
	assign red_next = visible ? expand_bit(border[COLOR_RED])   : RGB2_OFF;
	assign grn_next = visible ? expand_bit(border[COLOR_GREEN]) : RGB2_OFF;
	assign blu_next = visible ? expand_bit(border[COLOR_BLUE])  : RGB2_OFF;

	assign csync_next = hsync | vsync;

	// every pin leaves a flop
	always_ff @(posedge fclk) begin
		if (rst) begin
			vred   <= RGB2_OFF;
			vgrn   <= RGB2_OFF;
			vblu   <= RGB2_OFF;
			vhsync <= 1'b0;
			vvsync <= 1'b0;
			vcsync <= 1'b0;
		end else begin
			vred   <= red_next;
			vgrn   <= grn_next;
			vblu   <= blu_next;
			vhsync <= hsync;
			vvsync <= vsync;
			vcsync <= csync_next;
		end
	end

endmodule

`default_nettype wire

/* rtl/video_raster.sv */
`include "video_macros.svh"

`default_nettype none

module video_raster import video_pkg::*; (
	input  wire     fclk,
	input  wire     rst,
	output hcount_t hcount,
	output vcount_t vcount,
	output logic    hsync,
	output logic    vsync,
	output logic    visible
);

	logic line_end;
	logic frame_end;
	logic h_active;
	logic v_active;

	assign line_end  = (hcount == hcount_t'(`H_TOTAL - 1));
	assign frame_end = (vcount == vcount_t'(`V_TOTAL - 1));

	// pixel counter, one step per fclk
	always_ff @(posedge fclk) begin
		if (rst) begin
			hcount <= '0;
		end else if (line_end) begin
			hcount <= '0;
		end else begin
			hcount <= hcount + 1'b1;
		end
	end

	// line counter steps on the horizontal wrap
	always_ff @(posedge fclk) begin
		if (rst) begin
			vcount <= '0;
		end else if (line_end) begin
			if (frame_end) begin
				vcount <= '0;
			end else begin
				vcount <= vcount + 1'b1;
			end
		end
	end

	assign hsync = (hcount >= hcount_t'(`HSYNC_START)) &&
	               (hcount <  hcount_t'(`HSYNC_END));
	assign vsync = (vcount >= vcount_t'(`VSYNC_START)) &&
	               (vcount <  vcount_t'(`VSYNC_END));

	// visible area starts at the top left corner
	assign h_active = (hcount < hcount_t'(`H_VISIBLE));
	assign v_active = (vcount < vcount_t'(`V_VISIBLE));
	assign visible  = h_active & v_active;

endmodule

`default_nettype wire

/* rtl/port_decoder.sv */
`default_nettype none

module port_decoder import zbus_pkg::*; (
	input  wire         fclk,
	input  wire         rst,
	input  wire         iowr_s,
	input  wire         port_lsb,
	input  wire zdata_t wr_data,
	output zx_color_t   border,
	output logic        beep
);

	logic      ula_wr;
	zx_color_t border_next;
	logic      beep_next;

	// any even port reaches the ULA
	assign ula_wr = iowr_s & ~port_lsb;

	// bits 3 and 5..7 go nowhere in this slice
	assign border_next = zx_color_t'(wr_data[BORDER_MSB:0]);
	assign beep_next   = wr_data[BEEP_BIT];

	always_ff @(posedge fclk) begin
		if (rst) begin
			border <= BORDER_BLACK;
			beep   <= 1'b0;
		end else if (ula_wr) begin
			border <= border_next;
			beep   <= beep_next;
		end
	end

endmodule

`default_nettype wire

/* rtl/zbus_sync.sv */
`default_nettype none

module zbus_sync import zbus_pkg::*; (
	input  wire         fclk,
	input  wire         rst,

	// raw z80 bus, asynchronous to fclk
	input  wire         iorq_n,
	input  wire         wr_n,
	input  wire         m1_n,
	input  wire         a0,
	input  wire zdata_t d,

	// fclk domain
	output logic        iowr_s,
	output logic        port_lsb,
	output zdata_t      wr_data
);

	// first stage may go metastable
	logic   iorq_n_meta;
	logic   wr_n_meta;
	logic   m1_n_meta;
	logic   a0_meta;
	zdata_t d_meta;

	// second stage, safe to use
	logic   iorq_n_s;
	logic   wr_n_s;
	logic   m1_n_s;
	logic   a0_s;
	zdata_t d_s;

	logic   io_write;
	logic   io_write_q;

	// strobes come out of reset inactive
	always_ff @(posedge fclk) begin
		if (rst) begin
			iorq_n_meta <= 1'b1;
			wr_n_meta   <= 1'b1;
			m1_n_meta   <= 1'b1;
			iorq_n_s    <= 1'b1;
			wr_n_s      <= 1'b1;
			m1_n_s      <= 1'b1;
		end else begin
			iorq_n_meta <= iorq_n;
			wr_n_meta   <= wr_n;
			m1_n_meta   <= m1_n;
			iorq_n_s    <= iorq_n_meta;
			wr_n_s      <= wr_n_meta;
			m1_n_s      <= m1_n_meta;
		end
	end

	always_ff @(posedge fclk) begin
		a0_meta <= a0;
		d_meta  <= d;
		a0_s    <= a0_meta;
		d_s     <= d_meta;
	end

	// io write, not an interrupt acknowledge
	assign io_write = ~iorq_n_s & ~wr_n_s & m1_n_s;

	always_ff @(posedge fclk) begin
		if (rst) begin
			io_write_q <= 1'b0;
			iowr_s     <= 1'b0;
		end else begin
			io_write_q <= io_write;
			iowr_s     <= io_write & ~io_write_q;
		end
	end

	// address and data land with the pulse
	always_ff @(posedge fclk) begin
		port_lsb <= a0_s;
		wr_data  <= d_s;
	end

endmodule

`default_nettype wire

/* rtl/video_pkg.sv */
`default_nettype none

package video_pkg;

	// counter widths, wide enough for the line and frame totals
	localparam int HCOUNT_W = 9;
	localparam int VCOUNT_W = 9;

	typedef logic [HCOUNT_W-1:0] hcount_t;
	typedef logic [VCOUNT_W-1:0] vcount_t;

	// one colour channel on the DAC pins
	typedef logic [1:0] rgb2_t;

	localparam rgb2_t RGB2_OFF = 2'b00;

	// a ULA colour bit drives both DAC bits of its channel
	function automatic rgb2_t expand_bit(input logic bit_in);
		rgb2_t chan;
		chan = {bit_in, bit_in};
		return chan;
	endfunction

endpackage

`default_nettype wire

/* rtl/zbus_pkg.sv */
`default_nettype none

package zbus_pkg;

	// one byte on the z80 data bus
	typedef logic [7:0] zdata_t;

	// ULA colour, same bit order as the border port
	typedef logic [2:0] zx_color_t;

	// bit positions inside zx_color_t
	localparam int COLOR_BLUE  = 0;
	localparam int COLOR_RED   = 1;
	localparam int COLOR_GREEN = 2;

	localparam zx_color_t BORDER_BLACK = 3'b000;

	// address bit that selects the ULA when low
	localparam int ULA_DECODE_BIT = 0;

	// fields of the byte written to the ULA port
	localparam int BORDER_MSB = 2;
	localparam int BEEP_BIT   = 4;

endpackage

`default_nettype wire

/* rtl/video_macros.svh */
`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

// raster geometry, one pixel per fclk cycle

// horizontal timing in fclk cycles
`define H_TOTAL      448
`define H_VISIBLE    320
`define HSYNC_START  352
`define HSYNC_END    384

// vertical timing in lines
`define V_TOTAL      312
`define V_VISIBLE    256
`define VSYNC_START  280
`define VSYNC_END    284

// sync windows are half open, start included and end excluded

`endif
